// ==== rtl/femto_pkg.sv ====
`default_nettype none

package femto_pkg;

    localparam int xlen = 32;

    // access size of a bus transfer
    typedef enum logic [1:0] {
        acc_byte,
        acc_half,
        acc_word
    } bus_acc_e;

    // request fields shared by every slave
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic            w_rb;
        bus_acc_e        acc;
        logic [xlen-1:0] wdata;
    } bus_req_t;

    // address map
    localparam logic [xlen-1:0] tcm_addr      = 32'h1000_0000;
    localparam logic [xlen-1:0] tcm_sel_mask  = 32'hffff_0000;

    localparam logic [xlen-1:0] gpio_addr     = 32'h2000_0000;
    localparam logic [xlen-1:0] gpio_sel_mask = 32'hffff_f000;

    localparam logic [xlen-1:0] tmr_addr      = 32'h2000_1000;
    localparam logic [xlen-1:0] tmr_sel_mask  = 32'hffff_f000;

    localparam logic [xlen-1:0] rst_addr      = 32'h2000_2000;
    localparam logic [xlen-1:0] rst_sel_mask  = 32'hffff_f000;

    // bit positions in the block reset vector
    typedef enum logic [1:0] {
        rst_tcm  = 2'd0,
        rst_gpio = 2'd1,
        rst_tmr  = 2'd2
    } rst_idx_e;

    localparam int rst_width = 3;

endpackage

`default_nettype wire

// ==== rtl/bus_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
    input  logic                         clk,
    input  logic                         rst_n,

    input  femto_pkg::bus_req_t          bus_req,
    input  logic                         bus_valid,
    output logic [femto_pkg::xlen-1:0]   bus_rdata,
    output logic                         bus_resp,
    output logic                         fault,

    output logic                         tcm_valid,
    output logic                         gpio_valid,
    output logic                         tmr_valid,
    output logic                         rst_valid,

    input  logic [femto_pkg::xlen-1:0]   tcm_rdata,
    input  logic [femto_pkg::xlen-1:0]   gpio_rdata,
    input  logic [femto_pkg::xlen-1:0]   tmr_rdata,
    input  logic [femto_pkg::xlen-1:0]   rst_rdata,

    input  logic                         tcm_resp,
    input  logic                         gpio_resp,
    input  logic                         tmr_resp,
    input  logic                         rst_resp,

    input  logic                         gpio_fault,
    input  logic                         tmr_fault,
    input  logic                         rst_fault
);
    import femto_pkg::*;

    // one-hot slave select
    typedef struct packed {
        logic tcm;
        logic gpio;
        logic tmr;
        logic rst;
    } slave_sel_t;

    slave_sel_t req_sel;
    slave_sel_t resp_sel;
    logic       misaligned;
    logic       dec_fault;

    always_comb begin
        req_sel.tcm  = (bus_req.addr & tcm_sel_mask)  == tcm_addr;
        req_sel.gpio = (bus_req.addr & gpio_sel_mask) == gpio_addr;
        req_sel.tmr  = (bus_req.addr & tmr_sel_mask)  == tmr_addr;
        req_sel.rst  = (bus_req.addr & rst_sel_mask)  == rst_addr;
    end

    always_comb begin
        case (bus_req.acc)
            acc_half: misaligned = bus_req.addr[0];
            acc_word: misaligned = |bus_req.addr[1:0];
            default:  misaligned = 1'b0;
        endcase
    end

    // no valid goes out on a decode fault
    assign tcm_valid  = bus_valid & req_sel.tcm  & ~misaligned;
    assign gpio_valid = bus_valid & req_sel.gpio & ~misaligned;
    assign tmr_valid  = bus_valid & req_sel.tmr  & ~misaligned;
    assign rst_valid  = bus_valid & req_sel.rst  & ~misaligned;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_sel  <= '0;
            dec_fault <= 1'b0;
        end else begin
            if (bus_valid) begin
                resp_sel <= misaligned ? slave_sel_t'('0) : req_sel;
            end
            if (bus_valid && (req_sel == '0 || misaligned)) begin
                dec_fault <= 1'b1;
            end
        end
    end

    // rdata follows the slave picked on the request cycle
    always_comb begin
        if (resp_sel.tcm) begin
            bus_rdata = tcm_rdata;
        end else if (resp_sel.gpio) begin
            bus_rdata = gpio_rdata;
        end else if (resp_sel.tmr) begin
            bus_rdata = tmr_rdata;
        end else if (resp_sel.rst) begin
            bus_rdata = rst_rdata;
        end else begin
            bus_rdata = '0;
        end
    end

    assign fault    = dec_fault | gpio_fault | tmr_fault | rst_fault;
    assign bus_resp = ~fault & (tcm_resp | gpio_resp | tmr_resp | rst_resp);

endmodule

`default_nettype wire

// ==== rtl/tcm_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcm_controller #(
    parameter int tcm_depth = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  femto_pkg::bus_req_t          req,
    input  logic                         valid,
    output logic [femto_pkg::xlen-1:0]   rdata,
    output logic                         resp
);
    import femto_pkg::*;

    localparam int idx_bits = $clog2(tcm_depth);
    localparam int n_lanes  = xlen / 8;

    logic [xlen-1:0]     mem [tcm_depth];
    logic [idx_bits-1:0] idx;
    logic [n_lanes-1:0]  lanes;

    assign idx = req.addr[idx_bits+1:2];

    // wdata arrives lane-aligned, same as rdata
    always_comb begin
        case (req.acc)
            acc_byte: lanes = n_lanes'(1) << req.addr[1:0];
            acc_half: lanes = req.addr[1] ? 4'b1100 : 4'b0011;
            default:  lanes = '1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n && valid && req.w_rb) begin
            for (int i = 0; i < n_lanes; i++) begin
                if (lanes[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !req.w_rb) begin
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp <= 1'b0;
        end else begin
            resp <= valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gpio_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_controller #(
    parameter int gpio_width = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  femto_pkg::bus_req_t          req,
    input  logic                         valid,
    output logic [femto_pkg::xlen-1:0]   rdata,
    output logic                         resp,
    output logic                         fault,
    input  logic [gpio_width-1:0]        gpio_i,
    output logic [gpio_width-1:0]        gpio_o,
    output logic [gpio_width-1:0]        gpio_oe
);
    import femto_pkg::*;

    typedef enum logic [1:0] {
        reg_out,
        reg_dir,
        reg_in
    } gpio_reg_e;

    logic [gpio_width-1:0] out_q;
    logic [gpio_width-1:0] dir_q;
    logic [gpio_width-1:0] in_meta;
    logic [gpio_width-1:0] in_q;
    gpio_reg_e             sel;
    logic                  wr_in;

    assign sel   = gpio_reg_e'(req.addr[3:2]);
    assign wr_in = valid && req.w_rb && sel == reg_in;

    // two-flop input synchronizer
    always_ff @(posedge clk) begin
        in_meta <= gpio_i;
        in_q    <= in_meta;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
            dir_q <= '0;
            resp  <= 1'b0;
            fault <= 1'b0;
        end else begin
            resp <= valid && !wr_in;
            if (wr_in) begin
                fault <= 1'b1;
            end
            if (valid && req.w_rb && sel == reg_out) begin
                out_q <= req.wdata[gpio_width-1:0];
            end
            if (valid && req.w_rb && sel == reg_dir) begin
                dir_q <= req.wdata[gpio_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !req.w_rb) begin
            case (sel)
                reg_out: rdata <= xlen'(out_q);
                reg_dir: rdata <= xlen'(dir_q);
                reg_in:  rdata <= xlen'(in_q);
                default: rdata <= '0;
            endcase
        end
    end

    assign gpio_o  = out_q;
    assign gpio_oe = dir_q;

endmodule

`default_nettype wire

// ==== rtl/timer_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_controller (
    input  logic                         clk,
    input  logic                         rst_n,
    input  femto_pkg::bus_req_t          req,
    input  logic                         valid,
    output logic [femto_pkg::xlen-1:0]   rdata,
    output logic                         resp,
    output logic                         fault,
    output logic                         irq
);
    import femto_pkg::*;

    typedef enum logic [1:0] {
        reg_count,
        reg_cmp,
        reg_ctrl
    } tmr_reg_e;

    logic [xlen-1:0] count_q;
    logic [xlen-1:0] cmp_q;
    logic            en_q;
    tmr_reg_e        sel;
    logic            bad_acc;
    logic            wr;

    assign sel     = tmr_reg_e'(req.addr[3:2]);
    // word access only
    assign bad_acc = valid && req.acc != acc_word;
    assign wr      = valid && req.w_rb && !bad_acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
            cmp_q   <= '0;
            en_q    <= 1'b0;
            resp    <= 1'b0;
            fault   <= 1'b0;
        end else begin
            resp <= valid && !bad_acc;
            if (bad_acc) begin
                fault <= 1'b1;
            end
            // software write wins over the increment
            if (wr && sel == reg_count) begin
                count_q <= req.wdata;
            end else if (en_q) begin
                count_q <= count_q + xlen'(1);
            end
            if (wr && sel == reg_cmp) begin
                cmp_q <= req.wdata;
            end
            if (wr && sel == reg_ctrl) begin
                en_q <= req.wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !req.w_rb) begin
            case (sel)
                reg_count: rdata <= count_q;
                reg_cmp:   rdata <= cmp_q;
                reg_ctrl:  rdata <= xlen'(en_q);
                default:   rdata <= '0;
            endcase
        end
    end

    assign irq = en_q && count_q >= cmp_q;

endmodule

`default_nettype wire

// ==== rtl/rst_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module rst_controller (
    input  logic                              clk,
    input  logic                              rst_n,
    input  femto_pkg::bus_req_t               req,
    input  logic                              valid,
    output logic [femto_pkg::xlen-1:0]        rdata,
    output logic                              resp,
    output logic                              fault,
    output logic [femto_pkg::rst_width-1:0]   rst_vec
);
    import femto_pkg::*;

    logic [1:0]           sync_q;
    logic [rst_width-1:0] hold_q;
    logic                 bad_acc;
    logic                 hit;

    assign bad_acc = valid && req.acc != acc_word;
    // only the hold register at offset 0
    assign hit     = req.addr[11:2] == '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '0;
            hold_q <= '0;
            resp   <= 1'b0;
            fault  <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
            resp   <= valid && !bad_acc;
            if (bad_acc) begin
                fault <= 1'b1;
            end
            if (valid && req.w_rb && !bad_acc && hit) begin
                hold_q <= req.wdata[rst_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !req.w_rb) begin
            rdata <= hit ? xlen'(hold_q) : '0;
        end
    end

    // bit i low holds block i in reset
    assign rst_vec = {rst_width{sync_q[1]}} & ~hold_q;

endmodule

`default_nettype wire

// ==== rtl/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
    parameter int tcm_depth  = 256,
    parameter int gpio_width = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  femto_pkg::bus_req_t          bus_req,
    input  logic                         bus_valid,
    output logic [femto_pkg::xlen-1:0]   bus_rdata,
    output logic                         bus_resp,
    output logic                         fault,

    input  logic [gpio_width-1:0]        gpio_i,
    output logic [gpio_width-1:0]        gpio_o,
    output logic [gpio_width-1:0]        gpio_oe,

    output logic                         tmr_irq
);
    import femto_pkg::*;

    logic                 tcm_valid;
    logic                 gpio_valid;
    logic                 tmr_valid;
    logic                 rst_valid;

    logic [xlen-1:0]      tcm_rdata;
    logic [xlen-1:0]      gpio_rdata;
    logic [xlen-1:0]      tmr_rdata;
    logic [xlen-1:0]      rst_rdata;

    logic                 tcm_resp;
    logic                 gpio_resp;
    logic                 tmr_resp;
    logic                 rst_resp;

    logic                 gpio_fault;
    logic                 tmr_fault;
    logic                 rst_fault;

    // active low, one bit per block
    logic [rst_width-1:0] rst_vec;

    bus_fabric bus_fabric (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .bus_req    (bus_req   ),
        .bus_valid  (bus_valid ),
        .bus_rdata  (bus_rdata ),
        .bus_resp   (bus_resp  ),
        .fault      (fault     ),
        .tcm_valid  (tcm_valid ),
        .gpio_valid (gpio_valid),
        .tmr_valid  (tmr_valid ),
        .rst_valid  (rst_valid ),
        .tcm_rdata  (tcm_rdata ),
        .gpio_rdata (gpio_rdata),
        .tmr_rdata  (tmr_rdata ),
        .rst_rdata  (rst_rdata ),
        .tcm_resp   (tcm_resp  ),
        .gpio_resp  (gpio_resp ),
        .tmr_resp   (tmr_resp  ),
        .rst_resp   (rst_resp  ),
        .gpio_fault (gpio_fault),
        .tmr_fault  (tmr_fault ),
        .rst_fault  (rst_fault )
    );

    rst_controller rst_controller (
        .clk     (clk      ),
        .rst_n   (rst_n    ),
        .req     (bus_req  ),
        .valid   (rst_valid),
        .rdata   (rst_rdata),
        .resp    (rst_resp ),
        .fault   (rst_fault),
        .rst_vec (rst_vec  )
    );

    tcm_controller #(
        .tcm_depth(tcm_depth)
    ) tcm_controller (
        .clk   (clk              ),
        .rst_n (rst_vec[rst_tcm] ),
        .req   (bus_req          ),
        .valid (tcm_valid        ),
        .rdata (tcm_rdata        ),
        .resp  (tcm_resp         )
    );

    gpio_controller #(
        .gpio_width(gpio_width)
    ) gpio_controller (
        .clk     (clk              ),
        .rst_n   (rst_vec[rst_gpio]),
        .req     (bus_req          ),
        .valid   (gpio_valid       ),
        .rdata   (gpio_rdata       ),
        .resp    (gpio_resp        ),
        .fault   (gpio_fault       ),
        .gpio_i  (gpio_i           ),
        .gpio_o  (gpio_o           ),
        .gpio_oe (gpio_oe          )
    );

    timer_controller timer_controller (
        .clk   (clk             ),
        .rst_n (rst_vec[rst_tmr]),
        .req   (bus_req         ),
        .valid (tmr_valid       ),
        .rdata (tmr_rdata       ),
        .resp  (tmr_resp        ),
        .fault (tmr_fault       ),
        .irq   (tmr_irq         )
    );

endmodule

`default_nettype wire

// ==== sim/tb_soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;
    import femto_pkg::*;

    localparam int tcm_depth    = 256;
    localparam int gpio_width   = 8;
    localparam int resp_timeout = 10;
    localparam int irq_timeout  = 200;
    localparam int poll_limit   = 10;
    // the random TCM test stays inside this many words
    localparam int tcm_window   = 32;

    logic                  clk;
    logic                  rst_n;
    bus_req_t              bus_req;
    logic                  bus_valid;
    logic [xlen-1:0]       bus_rdata;
    logic                  bus_resp;
    logic                  fault;
    logic [gpio_width-1:0] gpio_i;
    logic [gpio_width-1:0] gpio_o;
    logic [gpio_width-1:0] gpio_oe;
    logic                  tmr_irq;

    logic [31:0] rng_state;
    logic [31:0] tcm_model [tcm_window];
    int          test_errors;
    int          tests_ok;
    int          tests_bad;

    soc_top #(
        .tcm_depth (tcm_depth ),
        .gpio_width(gpio_width)
    ) DUT (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .bus_req  (bus_req  ),
        .bus_valid(bus_valid),
        .bus_rdata(bus_rdata),
        .bus_resp (bus_resp ),
        .fault    (fault    ),
        .gpio_i   (gpio_i   ),
        .gpio_o   (gpio_o   ),
        .gpio_oe  (gpio_oe  ),
        .tmr_irq  (tmr_irq  )
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            test_errors++;
        end
    endtask

    // one request pulse, then watch for the response at falling edges
    task automatic issue_access(input logic w_rb, input logic [31:0] addr, input bus_acc_e acc,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic got_resp);
        int waited;
        @(posedge clk);
        bus_req.addr  <= addr;
        bus_req.w_rb  <= w_rb;
        bus_req.acc   <= acc;
        bus_req.wdata <= wdata;
        bus_valid     <= 1'b1;
        @(posedge clk);
        bus_valid <= 1'b0;
        got_resp = 1'b0;
        rdata    = '0;
        waited   = 0;
        while (!got_resp && waited < resp_timeout) begin
            @(negedge clk);
            if (bus_resp) begin
                got_resp = 1'b1;
                rdata    = bus_rdata;
            end
            waited++;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input bus_acc_e acc,
                             input logic [31:0] data);
        logic [31:0] ignored;
        logic        got;
        issue_access(1'b1, addr, acc, data, ignored, got);
        check_true($sformatf("no bus response to write at %h", addr), got);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        logic got;
        issue_access(1'b0, addr, acc_word, '0, data, got);
        check_true($sformatf("no bus response to read at %h", addr), got);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        bus_valid <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // block resets release two cycles after rst_n
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_true("fault high after reset", !fault);
        check_true("bus_resp high after reset", !bus_resp);
        check_true("tmr_irq high after reset", !tmr_irq);
        check_value("gpio_oe_reset", 32'h0, 32'(gpio_oe));
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_bad++;
        end
        test_errors = 0;
    endtask

    task automatic tcm_lane_test();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] mask;
        logic [31:0] word_addr;
        logic [4:0]  idx;
        logic [1:0]  lo;
        bus_acc_e    acc;
        for (int i = 0; i < tcm_window; i++) begin
            data = next_rand();
            write_reg(tcm_addr + 32'(i * 4), acc_word, data);
            tcm_model[i] = data;
        end
        for (int n = 0; n < 60; n++) begin
            r    = next_rand();
            data = next_rand();
            idx  = r[12:8];
            case (r[1:0])
                2'd0: begin
                    acc  = acc_byte;
                    lo   = r[3:2];
                    mask = 32'h0000_00ff << (8 * lo);
                end
                2'd1: begin
                    acc  = acc_half;
                    lo   = {r[2], 1'b0};
                    mask = r[2] ? 32'hffff_0000 : 32'h0000_ffff;
                end
                default: begin
                    acc  = acc_word;
                    lo   = 2'b00;
                    mask = 32'hffff_ffff;
                end
            endcase
            word_addr = tcm_addr + 32'({idx, 2'b00});
            write_reg(word_addr | 32'(lo), acc, data);
            tcm_model[idx] = (tcm_model[idx] & ~mask) | (data & mask);
            read_reg(word_addr, rdata);
            check_value("tcm_rw", tcm_model[idx], rdata);
        end
        finish_test("tcm");
    endtask

    task automatic gpio_test();
        logic [31:0] r;
        logic [31:0] out_val;
        logic [31:0] dir_val;
        logic [31:0] in_val;
        logic [31:0] rdata;
        int          polls;
        r       = next_rand();
        out_val = 32'(r[7:0]);
        dir_val = 32'(r[15:8]);
        in_val  = 32'(r[23:16] | 8'h80);
        write_reg(gpio_addr, acc_word, out_val);
        write_reg(gpio_addr + 32'h4, acc_word, dir_val);
        check_value("gpio_o", out_val, 32'(gpio_o));
        check_value("gpio_oe", dir_val, 32'(gpio_oe));
        read_reg(gpio_addr, rdata);
        check_value("gpio_out_read", out_val, rdata);
        @(posedge clk);
        gpio_i <= in_val[gpio_width-1:0];
        polls = 0;
        rdata = ~in_val;
        while (rdata !== in_val && polls < poll_limit) begin
            read_reg(gpio_addr + 32'h8, rdata);
            polls++;
        end
        check_value("gpio_in", in_val, rdata);
        finish_test("gpio");
    endtask

    task automatic timer_test();
        logic [31:0] cmp_val;
        logic [31:0] rdata;
        int          waited;
        cmp_val = 32'd24;
        write_reg(tmr_addr + 32'h4, acc_word, cmp_val);
        // count already past cmp while the timer is off
        write_reg(tmr_addr, acc_word, cmp_val + 32'd8);
        check_true("tmr_irq high while the timer is disabled", !tmr_irq);
        write_reg(tmr_addr, acc_word, 32'h0);
        write_reg(tmr_addr + 32'h8, acc_word, 32'h1);
        waited = 0;
        while (!tmr_irq && waited < irq_timeout) begin
            @(negedge clk);
            waited++;
        end
        check_true("tmr_irq did not rise before the timeout", tmr_irq);
        read_reg(tmr_addr, rdata);
        assert (rdata >= cmp_val) else begin
            $display("Fail timer_count expected >= %h actual %h", cmp_val, rdata);
            test_errors++;
        end
        write_reg(tmr_addr + 32'h8, acc_word, 32'h0);
        finish_test("timer");
    endtask

    task automatic reset_hold_test();
        logic [31:0] rdata;
        logic        got;
        write_reg(gpio_addr, acc_word, 32'h0000_00a5);
        check_value("gpio_o_before_hold", 32'h0000_00a5, 32'(gpio_o));
        write_reg(rst_addr, acc_word, 32'h1 << rst_gpio);
        read_reg(rst_addr, rdata);
        check_value("rst_hold_read", 32'h1 << rst_gpio, rdata);
        check_value("gpio_o_held", 32'h0, 32'(gpio_o));
        // a block held in reset stays silent
        issue_access(1'b0, gpio_addr, acc_word, '0, rdata, got);
        check_true("held gpio block answered a read", !got);
        write_reg(rst_addr, acc_word, 32'h0);
        read_reg(gpio_addr, rdata);
        check_value("gpio_out_after_hold", 32'h0, rdata);
        for (int i = 0; i < tcm_window; i++) begin
            read_reg(tcm_addr + 32'(i * 4), rdata);
            check_value("tcm_after_hold", tcm_model[i], rdata);
        end
        finish_test("reset_hold");
    endtask

    task automatic expect_fault(input string what, input logic [31:0] addr, input bus_acc_e acc);
        logic [31:0] rdata;
        logic        got;
        apply_reset();
        read_reg(tcm_addr, rdata);
        check_value("tcm_after_reset", tcm_model[0], rdata);
        issue_access(1'b0, addr, acc, '0, rdata, got);
        check_true($sformatf("%s got a bus response", what), !got);
        check_true($sformatf("%s did not raise fault", what), fault);
    endtask

    task automatic fault_test();
        logic [31:0] rdata;
        expect_fault("misaligned word read", tcm_addr + 32'h2, acc_word);
        expect_fault("unmapped read", 32'h3000_0000, acc_word);
        expect_fault("byte access to the timer", tmr_addr, acc_byte);
        apply_reset();
        read_reg(rst_addr, rdata);
        check_value("rst_hold_after_fault", 32'h0, rdata);
        finish_test("faults");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        bus_valid   = 1'b0;
        bus_req     = '0;
        gpio_i      = '0;
        rng_state   = 32'h2043;
        test_errors = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        apply_reset();
        finish_test("reset_state");
        tcm_lane_test();
        gpio_test();
        timer_test();
        reset_hold_test();
        fault_test();
        $display("summary: %0d ok, %0d with errors", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // whole-run limit in case a loop above never exits
    initial begin
        #2_000_000;
        $display("simulation ran past its time limit");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_top.f ====
rtl/femto_pkg.sv
rtl/bus_fabric.sv
rtl/tcm_controller.sv
rtl/gpio_controller.sv
rtl/timer_controller.sv
rtl/rst_controller.sv
rtl/soc_top.sv
sim/tb_soc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs tb_soc_top with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_soc_top -f soc_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_soc_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^test passed$"; then
    exit 0
fi
exit 1
